//--- mmuTop.f
+incdir+.
tlbPkg.sv
accessPkg.sv
tlbArray.sv
mmuRegs.sv
addrTranslator.sv
mmuTop.sv
mmuTop_sva.sv
mmuTop_tb.sv

//--- mmuTop_tb.sv
/*
 * Testbench for the MMU top level
 *   clock, reset and LFSR stimulus source
 *   reference TLB model that mirrors every TLBW
 *   directed tests: reset state, unmapped windows, TLBW/TLBR,
 *   mapped refill, fault classes and TLBP
 *   cycle timeout and error summary
 */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module mmuTop_tb
    import tlbPkg::*;
    import accessPkg::*;
();

    localparam int CYCLE_LIMIT = 3000;  // tests take a few hundred cycles

    logic        clk;
    logic        rstN;
    accessReqT   fetchReq;
    accessReqT   dataReq;
    transRespT   fetchResp;
    transRespT   dataResp;
    logic        probe;
    logic        tlbWrite;
    logic        tlbRead;
    logic        bufferFlush;
    logic        cp0Wr;
    regSelT      cp0Sel;
    logic [31:0] cp0Wdata;
    logic [31:0] cp0Rdata;

    tlbEntryT              refTlb [`TLB_ENTRIES];  // mirror of the TLB
    logic [`ASID_W-1:0]    curAsid;                // EntryHi asid
    logic [`TLB_IDX_W-1:0] refIndex;               // Index low bits
    logic [31:0]           lfsr = 32'h95ec804b;
    int                    errors = 0;
    int                    cycles = 0;

    mmuTop mmuTop_inst (
        .clk         (clk),
        .rstN        (rstN),
        .fetchReq    (fetchReq),
        .dataReq     (dataReq),
        .fetchResp   (fetchResp),
        .dataResp    (dataResp),
        .probe       (probe),
        .tlbWrite    (tlbWrite),
        .tlbRead     (tlbRead),
        .bufferFlush (bufferFlush),
        .cp0Wr       (cp0Wr),
        .cp0Sel      (cp0Sel),
        .cp0Wdata    (cp0Wdata),
        .cp0Rdata    (cp0Rdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per returned bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic logic isMapped(input logic [31:0] va);
        return !((va >= `KSEG0_BASE) && (va < `KSEG2_BASE));
    endfunction

    // reference entry matching vpn2 under the current asid, -1 on a miss
    function automatic int refFind(input logic [`VPN2_W-1:0] vpn2);
        int hit;
        hit = -1;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (refTlb[i].vpn2 == vpn2 && (refTlb[i].global || refTlb[i].asid == curAsid)) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    function automatic faultT expFault(input accessReqT r);
        faultT    f;
        pageHalfT h;
        int       hit;
        f = '0;
        hit = refFind(r.vaddr[31:13]);
        if (isMapped(r.vaddr) && (r.read || r.write)) begin
            if (hit < 0) begin
                f.refill = 1'b1;
            end else begin
                h = r.vaddr[12] ? refTlb[hit].odd : refTlb[hit].even;
                if (!h.valid) begin
                    f.invalid = 1'b1;
                end else if (r.write && !h.dirty) begin
                    f.modified = 1'b1;   // store to a clean page
                end
            end
        end
        return f;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // first cycle of the request counts as cycle one
    task automatic waitValid(input logic onFetch, input int maxCycles);
        int n;
        n = 1;
        #1;
        while (!(onFetch ? fetchResp.bufValid : dataResp.bufValid) && n < maxCycles) begin
            tick();
            #1;
            n++;
        end
        if (!(onFetch ? fetchResp.bufValid : dataResp.bufValid)) begin
            errors++;
            $display("ERROR at %0t: %s bufValid did not rise within %0d cycles",
                     $time, onFetch ? "fetchResp" : "dataResp", maxCycles);
        end
    endtask

    task automatic writeReg(input regSelT sel, input logic [31:0] data);
        cp0Sel   = sel;
        cp0Wdata = data;
        cp0Wr    = 1'b1;
        tick();
        cp0Wr    = 1'b0;
        if (sel == selEntryHi) begin
            curAsid = data[`ASID_W-1:0];
        end else if (sel == selIndex) begin
            refIndex = data[`TLB_IDX_W-1:0];
        end
    endtask

    task automatic readReg(input regSelT sel, output logic [31:0] data);
        cp0Sel = sel;
        #1;
        data = cp0Rdata;
        tick();
    endtask

    task automatic writeTlb(input int idx, input logic [31:0] hi, input logic [31:0] lo0,
                            input logic [31:0] lo1);
        writeReg(selEntryHi, hi);
        writeReg(selEntryLo0, lo0);
        writeReg(selEntryLo1, lo1);
        writeReg(selIndex, 32'(idx));
        tlbWrite = 1'b1;
        tick();
        tlbWrite = 1'b0;
        refTlb[idx] = '{vpn2: hi[31:13], asid: hi[7:0], global: lo0[0] & lo1[0],
                        even: lo0[25:1], odd: lo1[25:1]};
    endtask

    task automatic checkFaults();
        #1;
        compare("fetchResp.fault", 32'(expFault(fetchReq)), 32'(fetchResp.fault));
        compare("dataResp.fault", 32'(expFault(dataReq)), 32'(dataResp.fault));
        tick();
    endtask

    task automatic resetTest();
        logic [31:0] got;
        for (int s = 0; s < 4; s++) begin
            readReg(regSelT'(s), got);
            compare("cp0Rdata after reset", 32'h0, got);
        end
    endtask

    // park every entry on an invalid kseg0 page so no search sees an unknown entry
    task automatic initTlb();
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            writeTlb(i, {3'b100, 16'(i), 13'h0}, 32'h0, 32'h0);
        end
    endtask

    task automatic unmappedTest();
        logic [28:0] off0;
        logic [28:0] off1;
        for (int i = 0; i < 8; i++) begin
            off0 = 29'(randBits(29));
            off1 = 29'(randBits(29));
            fetchReq = '{vaddr: {3'b100, off0}, read: 1'b1, write: 1'b0};   // kseg0
            dataReq  = '{vaddr: {3'b101, off1}, read: 1'b0, write: 1'b1};   // kseg1
            #1;
            compare("fetchResp.paddr", 32'(off0), fetchResp.paddr);
            compare("fetchResp.cached", 32'd1, 32'(fetchResp.cached));
            compare("fetchResp.bufValid", 32'd1, 32'(fetchResp.bufValid));
            compare("fetchResp.fault", 32'd0, 32'(fetchResp.fault));
            compare("dataResp.paddr", 32'(off1), dataResp.paddr);
            compare("dataResp.cached", 32'd0, 32'(dataResp.cached));
            compare("dataResp.bufValid", 32'd1, 32'(dataResp.bufValid));
            compare("dataResp.fault", 32'd0, 32'(dataResp.fault));
            tick();
        end
        fetchReq = '0;
        dataReq  = '0;
    endtask

    task automatic roundTripTest();
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo0;
        logic [31:0] lo1;
        logic [31:0] got;
        logic        g;
        r   = randBits(24);
        hi  = {3'b100, r[23:8], 5'b0, r[7:0]};  // kseg0 page, never searched
        lo0 = {6'b0, 26'(randBits(26))};
        lo1 = {6'b0, 26'(randBits(26))};
        g   = lo0[0] & lo1[0];
        writeTlb(5, hi, lo0, lo1);
        writeReg(selEntryHi, 32'h0);
        writeReg(selEntryLo0, 32'h0);
        writeReg(selEntryLo1, 32'h0);
        tlbRead = 1'b1;
        tick();
        tlbRead = 1'b0;
        curAsid = hi[7:0];   // TLBR reloads EntryHi
        readReg(selEntryHi, got);
        compare("cp0Rdata (EntryHi)", {hi[31:13], 5'b0, hi[7:0]}, got);
        readReg(selEntryLo0, got);
        compare("cp0Rdata (EntryLo0)", {6'b0, lo0[25:1], g}, got);
        readReg(selEntryLo1, got);
        compare("cp0Rdata (EntryLo1)", {6'b0, lo1[25:1], g}, got);
    endtask

    task automatic mappedTest();
        logic [31:0]        r;
        logic [31:0]        va;
        logic [`VPN2_W-1:0] vpn2;
        pageHalfT           h;
        int                 hit;
        r    = randBits(16);
        vpn2 = {3'b000, r[15:0]};
        writeTlb(2, {vpn2, 5'b0, 8'h11},
                 {6'b0, 20'(randBits(20)), 3'd3, 1'b1, 1'b1, 1'b0},   // even cached
                 {6'b0, 20'(randBits(20)), 3'd2, 1'b0, 1'b1, 1'b0});  // odd uncached
        for (int half = 0; half < 2; half++) begin
            r  = randBits(12);
            va = {vpn2, half[0], r[11:0]};
            fetchReq = '{vaddr: va, read: 1'b1, write: 1'b0};
            waitValid(1'b1, 2);
            hit = refFind(va[31:13]);
            h   = va[12] ? refTlb[hit].odd : refTlb[hit].even;
            compare("fetchResp.paddr", {h.pfn, va[11:0]}, fetchResp.paddr);
            compare("fetchResp.cached", 32'(h.attr == `CACHED_ATTR), 32'(fetchResp.cached));
            compare("fetchResp.fault", 32'(expFault(fetchReq)), 32'(fetchResp.fault));
            tick();
        end
        bufferFlush = 1'b1;
        tick();
        bufferFlush = 1'b0;
        #1;
        compare("fetchResp.bufValid after flush", 32'd0, 32'(fetchResp.bufValid));
        tick();
        fetchReq = '0;
    endtask

    task automatic faultTest();
        logic [31:0]        r;
        logic [`VPN2_W-1:0] vpnA;
        logic [`VPN2_W-1:0] vpnB;
        logic [`VPN2_W-1:0] vpnC;
        r    = randBits(16);
        vpnA = {3'b001, r[15:0]};
        vpnB = {3'b010, r[15:0]};
        vpnC = {3'b011, r[15:0]};   // never written
        writeTlb(3, {vpnA, 5'b0, 8'h11},
                 {6'b0, 20'(randBits(20)), 3'd3, 1'b1, 1'b0, 1'b0},   // even invalid
                 {6'b0, 20'(randBits(20)), 3'd3, 1'b0, 1'b1, 1'b0});  // odd clean
        writeTlb(4, {vpnB, 5'b0, 8'h11},
                 {6'b0, 20'(randBits(20)), 3'd3, 1'b1, 1'b1, 1'b0},   // even dirty
                 {6'b0, 20'(randBits(20)), 3'd3, 1'b1, 1'b1, 1'b0});
        fetchReq = '{vaddr: {vpnC, 13'h0040}, read: 1'b1, write: 1'b0};
        dataReq  = '{vaddr: {vpnC, 13'h1040}, read: 1'b1, write: 1'b0};
        checkFaults();      // refill
        fetchReq = '{vaddr: {vpnA, 13'h0100}, read: 1'b1, write: 1'b0};
        dataReq  = '{vaddr: {vpnA, 13'h0200}, read: 1'b1, write: 1'b0};
        checkFaults();      // invalid
        fetchReq = '0;
        dataReq  = '{vaddr: {vpnA, 13'h1300}, read: 1'b0, write: 1'b1};
        checkFaults();      // modified
        #1;
        compare("dataResp.bufValid on clean store", 32'd0, 32'(dataResp.bufValid));
        tick();
        dataReq = '{vaddr: {vpnB, 13'h0400}, read: 1'b0, write: 1'b1};
        waitValid(1'b0, 2);
        compare("dataResp.fault", 32'(expFault(dataReq)), 32'(dataResp.fault));
        tick();
        dataReq = '0;
        writeReg(selEntryHi, {vpnC, 5'b0, 8'h22});
        dataReq = '{vaddr: {vpnB, 13'h0400}, read: 1'b1, write: 1'b0};
        checkFaults();      // asid mismatch, refill
        dataReq = '0;
        writeReg(selEntryHi, {vpnC, 5'b0, 8'h11});
    endtask

    task automatic probeCheck(input logic [31:0] hi);
        logic [31:0] got;
        logic [31:0] expected;
        int          hit;
        writeReg(selEntryHi, hi);
        probe = 1'b1;
        tick();
        probe = 1'b0;
        hit = refFind(hi[31:13]);
        if (hit >= 0) begin
            refIndex = `TLB_IDX_W'(hit);
            expected = 32'(hit);
        end else begin
            expected = {1'b1, 27'b0, refIndex};   // only the fail bit changes
        end
        readReg(selIndex, got);
        compare("cp0Rdata (Index)", expected, got);
    endtask

    task automatic probeTest();
        logic [31:0] r;
        fetchReq = '0;
        dataReq  = '0;
        probeCheck({refTlb[3].vpn2, 5'b0, refTlb[3].asid});
        r = randBits(16);
        probeCheck({3'b110, r[15:0], 5'b0, 8'h11});
    endtask

    initial begin
        rstN        = 1'b0;
        fetchReq    = '0;
        dataReq     = '0;
        probe       = 1'b0;
        tlbWrite    = 1'b0;
        tlbRead     = 1'b0;
        bufferFlush = 1'b0;
        cp0Wr       = 1'b0;
        cp0Sel      = selIndex;
        cp0Wdata    = 32'h0;
        curAsid     = '0;
        refIndex    = '0;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        tick();
        resetTest();
        initTlb();
        unmappedTest();
        roundTripTest();
        mappedTest();
        faultTest();
        probeTest();
        errors += mmuTop_inst.assertions.failCount;   // bound assertion failures
        $display("%0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mmuTop_sva.sv
/*
 * Bound assertions for the MMU top level
 *   at most one fault flag per port
 *   no bufValid on a mapped address right after reset or flush
 *   no fault flags for kseg0/kseg1 addresses
 *   count of failed assertions
 */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module mmuTop_sva import accessPkg::*; (
    input logic      clk,
    input logic      rstN,
    input logic      bufferFlush,
    input accessReqT fetchReq,
    input accessReqT dataReq,
    input transRespT fetchResp,
    input transRespT dataResp
);

    logic fetchMapped;
    logic dataMapped;
    int   failCount = 0;

    assign fetchMapped = !((fetchReq.vaddr >= `KSEG0_BASE) && (fetchReq.vaddr < `KSEG2_BASE));
    assign dataMapped  = !((dataReq.vaddr >= `KSEG0_BASE) && (dataReq.vaddr < `KSEG2_BASE));

    fetchOneFault: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(fetchResp.fault))
        else begin
            $error("fetch port raised more than one fault flag");
            failCount++;
        end
    dataOneFault: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(dataResp.fault))
        else begin
            $error("data port raised more than one fault flag");
            failCount++;
        end

    // buffer is empty for one cycle after reset or flush
    fetchBufCleared: assert property (@(posedge clk)
        (!rstN || bufferFlush) |=> !(fetchMapped && fetchResp.bufValid))
        else begin
            $error("fetch bufValid high right after reset or flush");
            failCount++;
        end
    dataBufCleared: assert property (@(posedge clk)
        (!rstN || bufferFlush) |=> !(dataMapped && dataResp.bufValid))
        else begin
            $error("data bufValid high right after reset or flush");
            failCount++;
        end

    fetchUnmappedClean: assert property (@(posedge clk) disable iff (!rstN)
        !fetchMapped |-> (fetchResp.fault == '0))
        else begin
            $error("fault flag on an unmapped fetch address");
            failCount++;
        end
    dataUnmappedClean: assert property (@(posedge clk) disable iff (!rstN)
        !dataMapped |-> (dataResp.fault == '0))
        else begin
            $error("fault flag on an unmapped data address");
            failCount++;
        end

endmodule

bind mmuTop mmuTop_sva assertions (
    .clk         (clk),
    .rstN        (rstN),
    .bufferFlush (bufferFlush),
    .fetchReq    (fetchReq),
    .dataReq     (dataReq),
    .fetchResp   (fetchResp),
    .dataResp    (dataResp)
);

`default_nettype wire

//--- mmuTop.sv
/*
 * MMU top level
 *   CP0 MMU registers, joint TLB
 *   fetch and data address translators
 */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module mmuTop
    import tlbPkg::*;
    import accessPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  accessReqT   fetchReq,
    input  accessReqT   dataReq,
    output transRespT   fetchResp,
    output transRespT   dataResp,
    input  logic        probe,
    input  logic        tlbWrite,
    input  logic        tlbRead,
    input  logic        bufferFlush,
    input  logic        cp0Wr,
    input  regSelT      cp0Sel,
    input  logic [31:0] cp0Wdata,
    output logic [31:0] cp0Rdata
);

    logic [`TLB_IDX_W-1:0] index;
    logic [`ASID_W-1:0]    asid;
    logic [`VPN2_W-1:0]    entryVpn2;
    tlbEntryT              writeEntry;
    tlbEntryT              readEntry;
    logic [`VPN2_W-1:0]    fetchVpn2;
    logic [`VPN2_W-1:0]    dataVpn2;
    logic                  fetchFound;
    logic                  dataFound;
    logic [`TLB_IDX_W-1:0] dataIndex;   // also the TLBP result
    tlbEntryT              fetchEntry;
    tlbEntryT              dataEntry;

    mmuRegs regs (
        .clk        (clk),
        .rstN       (rstN),
        .cp0Wr      (cp0Wr),
        .cp0Sel     (cp0Sel),
        .cp0Wdata   (cp0Wdata),
        .cp0Rdata   (cp0Rdata),
        .tlbRead    (tlbRead),
        .readEntry  (readEntry),
        .probe      (probe),
        .probeFound (dataFound),
        .probeIndex (dataIndex),
        .index      (index),
        .asid       (asid),
        .entryVpn2  (entryVpn2),
        .writeEntry (writeEntry)
    );

    tlbArray tlb (
        .clk        (clk),
        .rstN       (rstN),
        .probe      (probe),
        .probeVpn2  (entryVpn2),
        .asid       (asid),
        .fetchVpn2  (fetchVpn2),
        .dataVpn2   (dataVpn2),
        .fetchFound (fetchFound),
        .fetchEntry (fetchEntry),
        .dataFound  (dataFound),
        .dataIndex  (dataIndex),
        .dataEntry  (dataEntry),
        .tlbWrite   (tlbWrite),
        .index      (index),
        .writeEntry (writeEntry),
        .readEntry  (readEntry)
    );

    addrTranslator fetchXlate (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (bufferFlush),
        .req        (fetchReq),
        .asid       (asid),
        .searchVpn2 (fetchVpn2),
        .found      (fetchFound),
        .hitEntry   (fetchEntry),
        .resp       (fetchResp)
    );

    addrTranslator dataXlate (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (bufferFlush),
        .req        (dataReq),
        .asid       (asid),
        .searchVpn2 (dataVpn2),
        .found      (dataFound),
        .hitEntry   (dataEntry),
        .resp       (dataResp)
    );

endmodule

`default_nettype wire

//--- addrTranslator.sv
/*
 * Address translation for one access port
 *   kseg0/kseg1/mapped segment decode
 *   one-entry translation buffer refilled from the TLB
 *   physical address and cacheability
 *   refill, invalid and modified fault flags
 */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module addrTranslator
    import tlbPkg::*;
    import accessPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               flush,
    input  accessReqT          req,
    input  logic [`ASID_W-1:0] asid,
    output logic [`VPN2_W-1:0] searchVpn2,
    input  logic               found,
    input  tlbEntryT           hitEntry,
    output transRespT          resp
);

    logic     inKseg0;
    logic     inKseg1;
    logic     mapped;
    tlbEntryT entryBuf;     // translation buffer
    logic     bufMatch;
    logic     bufLoad;
    pageHalfT bufHalf;      // buffered half picked by vaddr[12]
    pageHalfT tlbHalf;      // half from the live TLB lookup
    logic     access;

    assign inKseg1 = (req.vaddr >= `KSEG1_BASE) && (req.vaddr < `KSEG2_BASE);
    assign inKseg0 = (req.vaddr >= `KSEG0_BASE) && (req.vaddr < `KSEG1_BASE);
    assign mapped  = !inKseg0 && !inKseg1;

    assign searchVpn2 = req.vaddr[31:13];

    assign bufMatch = (entryBuf.vpn2 == req.vaddr[31:13])
                   && (entryBuf.global || (entryBuf.asid == asid));
    assign bufLoad  = mapped && !bufMatch && found;

    // a zeroed buffer has both valid bits clear, so it never gives bufValid
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            entryBuf <= '0;
        end else if (bufLoad) begin
            entryBuf <= hitEntry;
        end
    end

    assign bufHalf = req.vaddr[12] ? entryBuf.odd : entryBuf.even;
    assign tlbHalf = req.vaddr[12] ? hitEntry.odd : hitEntry.even;

    always_comb begin
        if (inKseg1) begin
            resp.paddr    = req.vaddr - `KSEG1_BASE;
            resp.cached   = 1'b0;
            resp.bufValid = 1'b1;
        end else if (inKseg0) begin
            resp.paddr    = req.vaddr - `KSEG0_BASE;
            resp.cached   = 1'b1;
            resp.bufValid = 1'b1;
        end else begin
            resp.paddr    = {bufHalf.pfn, req.vaddr[11:0]};
            resp.cached   = (bufHalf.attr == `CACHED_ATTR);
            // store to a clean page must not go through
            resp.bufValid = bufMatch && bufHalf.valid && !(req.write && !bufHalf.dirty);
        end
    end

    // faults come straight from the TLB, not from the buffer
    assign access = mapped && (req.read || req.write);

    assign resp.fault.refill   = access && !found;
    assign resp.fault.invalid  = access && found && !tlbHalf.valid;
    assign resp.fault.modified = access && req.write && found
                              && tlbHalf.valid && !tlbHalf.dirty;

endmodule

`default_nettype wire

//--- mmuRegs.sv
/*
 * CP0 MMU registers
 *   Index, EntryHi, EntryLo0, EntryLo1
 *   software write and read mux
 *   TLBR load and TLBP result update
 *   write entry packing for TLBW
 */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module mmuRegs import tlbPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cp0Wr,
    input  regSelT                cp0Sel,
    input  logic [31:0]           cp0Wdata,
    output logic [31:0]           cp0Rdata,
    input  logic                  tlbRead,
    input  tlbEntryT              readEntry,
    input  logic                  probe,
    input  logic                  probeFound,
    input  logic [`TLB_IDX_W-1:0] probeIndex,
    output logic [`TLB_IDX_W-1:0] index,
    output logic [`ASID_W-1:0]    asid,
    output logic [`VPN2_W-1:0]    entryVpn2,
    output tlbEntryT              writeEntry
);

    logic     probeFail;    // Index bit 31
    pageHalfT lo0;
    pageHalfT lo1;
    logic     g0;
    logic     g1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            index     <= '0;
            probeFail <= 1'b0;
            entryVpn2 <= '0;
            asid      <= '0;
            lo0       <= '0;
            lo1       <= '0;
            g0        <= 1'b0;
            g1        <= 1'b0;
        end else if (cp0Wr) begin
            case (cp0Sel)
                selIndex: begin
                    index     <= cp0Wdata[`TLB_IDX_W-1:0];
                    probeFail <= cp0Wdata[31];
                end
                selEntryLo0: begin
                    lo0 <= cp0Wdata[25:1];  // pfn, attr, dirty, valid
                    g0  <= cp0Wdata[0];
                end
                selEntryLo1: begin
                    lo1 <= cp0Wdata[25:1];
                    g1  <= cp0Wdata[0];
                end
                default: begin              // EntryHi
                    entryVpn2 <= cp0Wdata[31:13];
                    asid      <= cp0Wdata[`ASID_W-1:0];
                end
            endcase
        end else if (tlbRead) begin
            entryVpn2 <= readEntry.vpn2;
            asid      <= readEntry.asid;
            lo0       <= readEntry.even;
            lo1       <= readEntry.odd;
            g0        <= readEntry.global;  // one G bit per entry
            g1        <= readEntry.global;
        end else if (probe) begin
            if (probeFound) begin
                index     <= probeIndex;
                probeFail <= 1'b0;
            end else begin
                probeFail <= 1'b1;          // index left as it was
            end
        end
    end

    always_comb begin
        case (cp0Sel)
            selIndex:    cp0Rdata = {probeFail, {(31 - `TLB_IDX_W){1'b0}}, index};
            selEntryLo0: cp0Rdata = {6'b0, lo0, g0};
            selEntryLo1: cp0Rdata = {6'b0, lo1, g1};
            default:     cp0Rdata = {entryVpn2, 5'b0, asid};
        endcase
    end

    // entry is global only if both halves say so
    assign writeEntry = '{
        vpn2:   entryVpn2,
        asid:   asid,
        global: g0 & g1,
        even:   lo0,
        odd:    lo1
    };

endmodule

`default_nettype wire

//--- tlbArray.sv
/*
 * Joint TLB storage
 *   write port at Index, combinational read port
 *   two associative search ports with priority encoders
 *   port 1 shared between data access and TLBP
 */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module tlbArray import tlbPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  probe,
    input  logic [`VPN2_W-1:0]    probeVpn2,
    input  logic [`ASID_W-1:0]    asid,
    input  logic [`VPN2_W-1:0]    fetchVpn2,
    input  logic [`VPN2_W-1:0]    dataVpn2,
    output logic                  fetchFound,
    output tlbEntryT              fetchEntry,
    output logic                  dataFound,
    output logic [`TLB_IDX_W-1:0] dataIndex,
    output tlbEntryT              dataEntry,
    input  logic                  tlbWrite,
    input  logic [`TLB_IDX_W-1:0] index,
    input  tlbEntryT              writeEntry,
    output tlbEntryT              readEntry
);

    tlbEntryT                 entries [`TLB_ENTRIES];
    logic [`VPN2_W-1:0]       port1Vpn2;
    logic [`TLB_ENTRIES-1:0]  fetchHits;
    logic [`TLB_ENTRIES-1:0]  dataHits;
    logic [`TLB_IDX_W-1:0]    fetchIndex;

    function automatic logic entryHit(input tlbEntryT e, input logic [`VPN2_W-1:0] vpn2,
                                      input logic [`ASID_W-1:0] curAsid);
        return (e.vpn2 == vpn2) && (e.global || (e.asid == curAsid));
    endfunction

    // lowest matching entry wins, entries should be unique anyway
    function automatic logic [`TLB_IDX_W-1:0] firstHit(input logic [`TLB_ENTRIES-1:0] hits);
        logic [`TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                idx = `TLB_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i].even.valid <= 1'b0;
                entries[i].odd.valid  <= 1'b0;
            end
        end else if (tlbWrite) begin
            entries[index] <= writeEntry;   // TLBW
        end
    end

    assign readEntry = entries[index];          // TLBR
    assign port1Vpn2 = probe ? probeVpn2 : dataVpn2;  // TLBP borrows the data port

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            fetchHits[i] = entryHit(entries[i], fetchVpn2, asid);
            dataHits[i]  = entryHit(entries[i], port1Vpn2, asid);
        end
    end

    assign fetchFound = |fetchHits;
    assign fetchIndex = firstHit(fetchHits);
    assign fetchEntry = entries[fetchIndex];

    assign dataFound  = |dataHits;
    assign dataIndex  = firstHit(dataHits);
    assign dataEntry  = entries[dataIndex];

endmodule

`default_nettype wire

//--- accessPkg.sv
/*
 * Access side types
 *   accessReqT  one fetch or data request
 *   faultT      TLB fault flags of one port
 *   transRespT  translated address and status
 */
`default_nettype none

package accessPkg;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        read;      // fetch or load
        logic        write;     // store
    } accessReqT;

    typedef struct packed {
        logic refill;    // no matching entry
        logic invalid;   // entry found, page not valid
        logic modified;  // store to a clean page
    } faultT;

    typedef struct packed {
        logic [31:0] paddr;
        logic        cached;
        logic        bufValid;  // paddr usable this cycle
        faultT       fault;
    } transRespT;

endpackage

`default_nettype wire

//--- tlbPkg.sv
/*
 * TLB types
 *   pageHalfT  one page of an even/odd pair
 *   tlbEntryT  a full joint TLB entry
 *   regSelT    CP0 MMU register selector
 */
`default_nettype none

`include "mmu_defines.svh"

package tlbPkg;

    // one half of a page pair, same field order as EntryLo[25:1]
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        attr;    // cache attribute
        logic              dirty;   // page writable
        logic              valid;
    } pageHalfT;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
        logic               global;  // ignore asid on match
        pageHalfT           even;    // vaddr[12] == 0
        pageHalfT           odd;     // vaddr[12] == 1
    } tlbEntryT;

    typedef enum logic [1:0] {
        selIndex    = 2'd0,
        selEntryLo0 = 2'd1,
        selEntryLo1 = 2'd2,
        selEntryHi  = 2'd3
    } regSelT;

endpackage

`default_nettype wire

//--- mmu_defines.svh
/*
 * MMU configuration macros
 *   TLB depth and index width
 *   virtual page pair, frame number and ASID widths
 *   kseg0/kseg1/kseg2 segment bounds
 *   cache attribute code for cached pages
 */
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

`define TLB_ENTRIES 16              // joint TLB depth
`define TLB_IDX_W   4               // log2 of TLB_ENTRIES

`define VPN2_W      19              // vaddr[31:13]
`define PFN_W       20              // paddr[31:12]
`define ASID_W      8

`define KSEG0_BASE  32'h8000_0000   // cached, unmapped
`define KSEG1_BASE  32'hA000_0000   // uncached, unmapped
`define KSEG2_BASE  32'hC000_0000   // mapped again from here

`define CACHED_ATTR 3'd3            // C field value for cacheable

`endif
